/* dv/noise_estimation_chk.sv */
// bound assertions on the controller: ready window, variance dispatch, frame end pulse
module noise_estimation_chk (
	input logic                        clk,
	input logic                        rst_n,
	input noise_ctrl_pkg::ctrl_state_t state,
	input logic                        sample_ready,
	input logic                        variance_start,
	input logic                        variance_busy,
	input logic                        frame_done // noise_valid one cycle later
);

	ready_only_in_read: assert property (@(posedge clk) disable iff (!rst_n)
		state != noise_ctrl_pkg::read_block |-> !sample_ready)
		else $error("sample_ready high outside read_block");

	start_when_free: assert property (@(posedge clk) disable iff (!rst_n)
		variance_start |-> !variance_busy)
		else $error("variance_start while the variance unit is busy");

	frame_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		frame_done |=> !frame_done)
		else $error("frame end strobe longer than one cycle, noise_valid would repeat");

endmodule

bind noise_estimation_fsm noise_estimation_chk chk0 (
	.clk            (clk),
	.rst_n          (rst_n),
	.state          (state),
	.sample_ready   (sample_ready),
	.variance_start (variance_start),
	.variance_busy  (variance_busy),
	.frame_done     (variance_done & variance_last)
);

/* dv/noise_estimation_tb.sv */
// noise estimator testbench: clock, reset, random frames, reference model, checks, watchdog
module noise_estimation_tb;

	// test5 worst case is four frames of 16 blocks
	localparam int max_samples     = 64 + 1024 + 256 + 256 + 4 * 1024;
	localparam int max_frames      = 8;
	localparam int watchdog_cycles = max_samples * 4 + max_frames * 200;

	logic                                clk;
	logic                                rst_n;
	logic                                start_of_frame;
	logic [2:0]                          blocks_log2;
	logic                                sample_valid;
	logic [noise_data_pkg::sample_w-1:0] sample_data;
	logic                                sample_ready;
	logic                                block_stat_valid;
	noise_data_pkg::block_stat_t         block_stat;
	logic                                noise_valid;
	noise_data_pkg::noise_result_t       noise_result;

	integer seed;
	int     errors;
	int     checks;
	int     tests_run;
	int     tests_bad;
	int     test_err_base;
	int     frame;

	// reference model state, updated from accepted samples
	int                            cap [64];
	int                            cap_fill;
	int                            frame_log2;
	int                            frame_blocks;  // blocks finished in this frame
	int                            frame_var_sum;
	int                            frame_accepts;
	int                            noise_seen;
	int                            blk_sum;
	int                            blk_mean;
	int                            blk_sq;
	int                            k;
	noise_data_pkg::block_stat_t   exp_stats [$];
	noise_data_pkg::noise_result_t exp_noise [$];
	noise_data_pkg::block_stat_t   stat_want;
	noise_data_pkg::noise_result_t noise_want;

	noise_estimation_top dut0 (
		.clk              (clk),
		.rst_n            (rst_n),
		.start_of_frame   (start_of_frame),
		.blocks_log2      (blocks_log2),
		.sample_valid     (sample_valid),
		.sample_data      (sample_data),
		.sample_ready     (sample_ready),
		.block_stat_valid (block_stat_valid),
		.block_stat       (block_stat),
		.noise_valid      (noise_valid),
		.noise_result     (noise_result)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles at %0t, DUT stopped responding",
			watchdog_cycles, $time);
		$display("Simulation failed");
		$finish;
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, want);
		errors++;
	endtask

	// model and output checks at the falling edge, where everything is stable
	always @(negedge clk) begin
		if (rst_n && sample_valid && sample_ready) begin
			cap[cap_fill] = sample_data;
			cap_fill      = cap_fill + 1;
			frame_accepts = frame_accepts + 1;
			if (cap_fill == 64) begin
				blk_sum = 0;
				for (k = 0; k < 64; k++)
					blk_sum = blk_sum + cap[k];
				blk_mean = blk_sum >> 6; // fraction dropped
				blk_sq   = 0;
				for (k = 0; k < 64; k++)
					blk_sq = blk_sq + (cap[k] - blk_mean) * (cap[k] - blk_mean);
				stat_want.mean        = blk_mean;
				stat_want.variance    = blk_sq >> 6;
				stat_want.block_index = frame_blocks;
				exp_stats.push_back(stat_want);
				frame_var_sum = frame_var_sum + (blk_sq >> 6);
				frame_blocks  = frame_blocks + 1;
				cap_fill      = 0;
				if (frame_blocks == (1 << frame_log2)) begin
					noise_want.noise_level = frame_var_sum >> frame_log2;
					noise_want.block_count = frame_blocks;
					exp_noise.push_back(noise_want);
				end
			end
		end
		if (block_stat_valid) begin
			if (exp_stats.size() == 0) begin
				$display("block result at %0t arrived with no block pending", $time);
				errors++;
			end else begin
				stat_want = exp_stats.pop_front();
				checks    = checks + 3;
				if (block_stat.mean !== stat_want.mean)
					report_mismatch("block_stat.mean", block_stat.mean, stat_want.mean);
				if (block_stat.variance !== stat_want.variance)
					report_mismatch("block_stat.variance", block_stat.variance, stat_want.variance);
				if (block_stat.block_index !== stat_want.block_index)
					report_mismatch("block_stat.block_index", block_stat.block_index,
						stat_want.block_index);
			end
		end
		if (noise_valid) begin
			noise_seen = noise_seen + 1;
			if (exp_noise.size() == 0) begin
				$display("noise result at %0t arrived before its frame was complete", $time);
				errors++;
			end else begin
				noise_want = exp_noise.pop_front();
				checks     = checks + 2;
				if (noise_result.noise_level !== noise_want.noise_level)
					report_mismatch("noise_result.noise_level", noise_result.noise_level,
						noise_want.noise_level);
				if (noise_result.block_count !== noise_want.block_count)
					report_mismatch("noise_result.block_count", noise_result.block_count,
						noise_want.block_count);
			end
		end
	end

	// holds valid until the DUT takes the sample, returns on the accepting edge
	task automatic send_sample(input logic [7:0] value, input int gap);
		bit taken;
		taken = 1'b0;
		if (gap > 0) begin
			sample_valid <= 1'b0;
			repeat (gap) @(posedge clk);
		end
		sample_valid <= 1'b1;
		sample_data  <= value;
		while (!taken) begin
			@(negedge clk);
			taken = sample_ready;
			@(posedge clk);
		end
	endtask

	// mode 0 random samples, mode 1 flat blocks alternating with 0/255 blocks
	task automatic run_frame(input int log2, input int mode, input bit gaps, input bit stray_sof);
		int         nblk;
		int         before_noise;
		int         b;
		int         s;
		logic [7:0] level;
		logic [7:0] value;
		nblk          = 1 << log2;
		frame_log2    = log2;
		frame_blocks  = 0;
		frame_var_sum = 0;
		frame_accepts = 0;
		cap_fill      = 0;
		before_noise  = noise_seen;
		blocks_log2    <= 3'(log2); // held until the frame result
		start_of_frame <= 1'b1;
		@(posedge clk);
		start_of_frame <= 1'b0;
		for (b = 0; b < nblk; b++) begin
			level = $random(seed);
			for (s = 0; s < 64; s++) begin
				if (mode == 0)
					value = $random(seed);
				else if (b % 2 == 0)
					value = level;
				else
					value = (s % 2 == 1) ? 8'd255 : 8'd0;
				send_sample(value, gaps ? ($unsigned($random(seed)) % 3) : 0);
			end
			if (stray_sof && b == 0) begin
				sample_valid   <= 1'b0;
				start_of_frame <= 1'b1; // frame already running
				@(posedge clk);
				start_of_frame <= 1'b0;
			end
		end
		// keep offering samples past the frame, none of them may be taken
		sample_valid <= 1'b1;
		while (noise_seen == before_noise) @(posedge clk);
		sample_valid <= 1'b0;
		repeat (2) @(posedge clk);
		checks = checks + 2;
		if (frame_accepts != 64 * nblk) begin
			$display("frame accepted %0d samples where %0d were due", frame_accepts, 64 * nblk);
			errors++;
		end
		if (noise_seen - before_noise != 1) begin
			$display("frame gave %0d noise results instead of one", noise_seen - before_noise);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != test_err_base)
			tests_bad++;
		$display("test %s finished with %0d errors", name, errors - test_err_base);
		test_err_base = errors;
	endtask

	initial begin
		seed           = 32'h270b9b5a;
		rst_n          = 1'b0;
		start_of_frame = 1'b0;
		blocks_log2    = 3'd0;
		sample_valid   = 1'b0;
		sample_data    = '0;
		errors         = 0;
		checks         = 0;
		tests_run      = 0;
		tests_bad      = 0;
		test_err_base  = 0;
		noise_seen     = 0;
		cap_fill       = 0;
		frame_log2     = 0;
		frame_blocks   = 0;
		frame_var_sum  = 0;
		frame_accepts  = 0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		// offered samples must be refused before the first frame
		sample_valid <= 1'b1;
		sample_data  <= 8'h5a;
		repeat (16) begin
			@(negedge clk);
			checks = checks + 2;
			if (sample_ready !== 1'b0)
				report_mismatch("sample_ready", sample_ready, 0);
			if (noise_valid !== 1'b0)
				report_mismatch("noise_valid", noise_valid, 0);
		end
		@(posedge clk);
		sample_valid <= 1'b0;
		end_test("reset_idle");

		run_frame(0, 0, 1'b0, 1'b0);
		end_test("single_block");
		run_frame(4, 0, 1'b0, 1'b0);
		end_test("sixteen_blocks");
		run_frame(2, 0, 1'b1, 1'b0);
		end_test("valid_gaps");
		run_frame(2, 1, 1'b0, 1'b0);
		end_test("flat_and_alternating");
		for (frame = 0; frame < 4; frame++)
			run_frame($unsigned($random(seed)) % 5, 0, frame % 2, 1'b1);
		end_test("back_to_back");

		if (exp_stats.size() != 0 || exp_noise.size() != 0) begin
			$display("%0d block and %0d noise results never came out",
				exp_stats.size(), exp_noise.size());
			errors++;
		end
		$display("%0d tests, %0d with errors, %0d checks, %0d errors",
			tests_run, tests_bad, checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* files.f */
verilog/noise_data_pkg.sv
verilog/noise_ctrl_pkg.sv
verilog/noise_estimation_fsm.sv
verilog/block_buffer.sv
verilog/block_mean.sv
verilog/block_variance.sv
verilog/noise_accumulator.sv
verilog/noise_estimation_top.sv
dv/noise_estimation_chk.sv
dv/noise_estimation_tb.sv

/* verilog/block_buffer.sv */
// two-bank ping-pong sample memory with a registered read port
module block_buffer (
	input  logic                                clk,
	input  logic                                wr_en,
	input  logic                                wr_bank,
	input  logic [noise_ctrl_pkg::addr_w-1:0]   wr_addr,
	input  logic [noise_data_pkg::sample_w-1:0] wr_data,
	input  logic                                rd_bank,
	input  logic [noise_ctrl_pkg::addr_w-1:0]   rd_addr,
	output logic [noise_data_pkg::sample_w-1:0] rd_data
);

	// bank 0 and bank 1, one block each
	logic [noise_data_pkg::sample_w-1:0] mem [2][noise_ctrl_pkg::block_samples];

	// capture side, fed by the controller
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_bank][wr_addr] <= wr_data;
	end

	// variance side, data one cycle after the address
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_bank][rd_addr];
	end

endmodule

/* verilog/block_mean.sv */
// running block sum and block mean, built while the block is captured
module block_mean (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                sample_accept,
	input  logic [noise_data_pkg::sample_w-1:0] sample_data,
	input  logic                                block_clear,
	output logic                                mean_ready,
	output logic [noise_data_pkg::sample_w-1:0] mean
);

	logic [noise_data_pkg::sum_w-1:0]    sum;
	logic [noise_data_pkg::sum_w-1:0]    sum_next;
	logic [noise_ctrl_pkg::block_log2-1:0] accept_cnt;
	logic                                block_full; // this accept is the 64th

	assign sum_next   = sum + sample_data;
	assign block_full = sample_accept && (&accept_cnt);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sum        <= '0;
			accept_cnt <= '0;
			mean_ready <= 1'b0;
		end else begin
			mean_ready <= block_full;
			if (block_clear) begin
				sum        <= '0;
				accept_cnt <= '0;
			end else if (sample_accept) begin
				sum        <= sum_next;
				accept_cnt <= accept_cnt + 1'b1; // wraps after 64
			end
		end
	end

	// sum >> 6, fraction dropped
	always_ff @(posedge clk) begin
		if (block_full)
			mean <= sum_next[noise_ctrl_pkg::block_log2 +: noise_data_pkg::sample_w];
	end

endmodule

/* verilog/block_variance.sv */
// second pass over a stored block: squared deviations from the mean, block variance
module block_variance (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                variance_start,
	input  noise_ctrl_pkg::variance_job_t       variance_job,
	input  logic [noise_data_pkg::sample_w-1:0] rd_data,
	output logic                                rd_bank,
	output logic [noise_ctrl_pkg::addr_w-1:0]   rd_addr,
	output logic                                variance_busy,
	output logic                                variance_done,
	output logic                                variance_last,
	output noise_data_pkg::block_stat_t         block_stat
);

	localparam logic [noise_ctrl_pkg::addr_w-1:0] last_addr = noise_ctrl_pkg::addr_w'(
		noise_ctrl_pkg::block_samples - 1);

	noise_ctrl_pkg::variance_job_t job_q;

	logic                                    reading;  // address phase active
	logic                                    rd_valid; // rd_data holds a sample
	logic                                    rd_final; // ...and it is the block's last
	logic [noise_data_pkg::sample_w-1:0]     dev;
	logic [2*noise_data_pkg::sample_w-1:0]   dev_sq;
	logic [noise_data_pkg::sq_sum_w-1:0]     sq_sum;
	logic [noise_data_pkg::sq_sum_w-1:0]     sq_sum_next;

	assign rd_bank = job_q.bank;

	// |sample - mean|, then squared
	assign dev         = (rd_data >= job_q.mean) ? rd_data - job_q.mean : job_q.mean - rd_data;
	assign dev_sq      = dev * dev;
	assign sq_sum_next = sq_sum + dev_sq;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reading       <= 1'b0;
			rd_addr       <= '0;
			rd_valid      <= 1'b0;
			rd_final      <= 1'b0;
			sq_sum        <= '0;
			variance_busy <= 1'b0;
			variance_done <= 1'b0;
			variance_last <= 1'b0;
		end else begin
			rd_valid      <= reading;
			rd_final      <= reading && (rd_addr == last_addr);
			variance_done <= rd_final; // output register stage
			if (variance_start) begin
				reading       <= 1'b1;
				rd_addr       <= '0;
				variance_busy <= 1'b1;
			end else if (reading) begin
				rd_addr <= rd_addr + 1'b1;
				if (rd_addr == last_addr)
					reading <= 1'b0;
			end
			if (rd_final) begin
				sq_sum        <= '0;
				variance_busy <= 1'b0; // bank is free again
				variance_last <= job_q.last;
			end else if (rd_valid) begin
				sq_sum <= sq_sum_next;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (variance_start)
			job_q <= variance_job;
		if (rd_final)
			block_stat <= '{
				mean:        job_q.mean,
				variance:    sq_sum_next[noise_ctrl_pkg::block_log2 +: noise_data_pkg::var_w],
				block_index: job_q.block_index
			};
	end

endmodule

/* verilog/noise_accumulator.sv */
// frame accumulator: sums block variances and produces the frame noise level
module noise_accumulator (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          variance_done,
	input  logic                          variance_last,
	input  noise_data_pkg::block_stat_t   block_stat,
	input  logic [2:0]                    blocks_log2,
	output logic                          noise_valid,
	output noise_data_pkg::noise_result_t noise_result
);

	logic [noise_data_pkg::noise_sum_w-1:0]   noise_sum;
	logic [noise_data_pkg::noise_sum_w-1:0]   noise_sum_next;
	logic [noise_data_pkg::noise_sum_w-1:0]   noise_shifted;
	logic [noise_ctrl_pkg::max_blocks_log2:0] block_cnt;
	logic [noise_ctrl_pkg::max_blocks_log2:0] block_cnt_next;

	assign noise_sum_next = noise_sum + block_stat.variance;
	assign block_cnt_next = block_cnt + 1'b1;
	assign noise_shifted  = noise_sum_next >> blocks_log2; // divide by block count

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			noise_sum   <= '0;
			block_cnt   <= '0;
			noise_valid <= 1'b0;
		end else begin
			noise_valid <= variance_done && variance_last;
			if (variance_done) begin
				if (variance_last) begin
					noise_sum <= '0; // ready for the next frame
					block_cnt <= '0;
				end else begin
					noise_sum <= noise_sum_next;
					block_cnt <= block_cnt_next;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (variance_done && variance_last)
			noise_result <= '{
				noise_level: noise_shifted[noise_data_pkg::var_w-1:0],
				block_count: block_cnt_next
			};
	end

endmodule

/* verilog/noise_ctrl_pkg.sv */
// block geometry, controller state encoding and variance job struct
package noise_ctrl_pkg;

	localparam int block_samples   = 64;
	localparam int block_log2      = 6;
	localparam int addr_w          = 6; // one bank of the ping-pong buffer
	localparam int max_blocks_log2 = 4; // at most 16 blocks per frame

	typedef enum logic [1:0] {
		idle          = 2'd0,
		read_block    = 2'd1, // accepting samples into the write bank
		wait_for_mean = 2'd2, // block full, waiting to hand it to the variance unit
		drain         = 2'd3  // last block dispatched, waiting for its variance
	} ctrl_state_t;

	// handed from the controller to block_variance with variance_start
	typedef struct packed {
		logic                                bank;
		logic [noise_data_pkg::sample_w-1:0] mean;
		logic [max_blocks_log2-1:0]          block_index;
		logic                                last; // final block of the frame
	} variance_job_t;

endpackage

/* verilog/noise_data_pkg.sv */
// sample, statistic and result widths, block statistic and frame result structs
package noise_data_pkg;

	localparam int sample_w    = 8;  // unsigned input sample
	localparam int sum_w       = 14; // 64 samples of 8 bits
	localparam int sq_sum_w    = 22; // 64 squared deviations of 16 bits
	localparam int var_w       = 16; // squared sum >> 6
	localparam int noise_sum_w = 20; // up to 16 variances

	// one finished block, sent out with block_stat_valid
	typedef struct packed {
		logic [sample_w-1:0] mean;
		logic [var_w-1:0]    variance;
		logic [3:0]          block_index; // position in the frame
	} block_stat_t;

	// frame result, sent out with noise_valid
	typedef struct packed {
		logic [var_w-1:0] noise_level;
		logic [4:0]       block_count; // 1 to 16
	} noise_result_t;

endpackage

/* verilog/noise_estimation_fsm.sv */
// frame and block sequencing controller: sample acceptance, buffer writes, variance dispatch
module noise_estimation_fsm (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  start_of_frame,
	input  logic [2:0]                            blocks_log2,
	input  logic                                  sample_valid,
	input  logic                                  mean_ready,
	input  logic [noise_data_pkg::sample_w-1:0]   mean,
	input  logic                                  variance_busy,
	input  logic                                  variance_done,
	input  logic                                  variance_last,
	output logic                                  sample_ready,
	output logic                                  wr_en,
	output logic                                  wr_bank,
	output logic [noise_ctrl_pkg::addr_w-1:0]     wr_addr,
	output logic                                  block_clear,
	output logic                                  variance_start,
	output noise_ctrl_pkg::variance_job_t         variance_job
);

	noise_ctrl_pkg::ctrl_state_t state, next_state;

	logic [noise_ctrl_pkg::addr_w-1:0]          sample_cnt;
	logic [noise_ctrl_pkg::max_blocks_log2-1:0] block_idx;
	logic [2:0]                                 blocks_q;    // frame size, held for the frame
	logic [noise_ctrl_pkg::max_blocks_log2:0]   block_total;
	logic                                       last_block;
	logic                                       mean_pend;   // mean arrived while unit was busy
	logic                                       have_mean;

	assign block_total = {{noise_ctrl_pkg::max_blocks_log2{1'b0}}, 1'b1} << blocks_q;
	assign last_block  = ({1'b0, block_idx} == block_total - 1'b1);
	assign have_mean   = mean_ready | mean_pend;

	assign wr_en   = sample_valid & sample_ready;
	assign wr_addr = sample_cnt;

	// job for the block just filled, mean held by block_mean until the next block
	assign variance_job = '{
		bank:        wr_bank,
		mean:        mean,
		block_index: block_idx,
		last:        last_block
	};

	always_comb begin
		next_state     = state;
		sample_ready   = 1'b0;
		block_clear    = 1'b0;
		variance_start = 1'b0;
		case (state)
			noise_ctrl_pkg::idle: begin
				if (start_of_frame) begin
					next_state  = noise_ctrl_pkg::read_block;
					block_clear = 1'b1;
				end
			end
			noise_ctrl_pkg::read_block: begin
				sample_ready = 1'b1;
				if (sample_valid && (&sample_cnt))
					next_state = noise_ctrl_pkg::wait_for_mean; // 64th sample taken
			end
			noise_ctrl_pkg::wait_for_mean: begin
				if (have_mean && !variance_busy) begin
					variance_start = 1'b1;
					if (last_block) begin
						next_state = noise_ctrl_pkg::drain;
					end else begin
						next_state  = noise_ctrl_pkg::read_block;
						block_clear = 1'b1;
					end
				end
			end
			noise_ctrl_pkg::drain: begin
				if (variance_done && variance_last)
					next_state = noise_ctrl_pkg::idle;
			end
			default: next_state = noise_ctrl_pkg::idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= noise_ctrl_pkg::idle;
			sample_cnt <= '0;
			block_idx  <= '0;
			blocks_q   <= '0;
			wr_bank    <= 1'b0;
			mean_pend  <= 1'b0;
		end else begin
			state <= next_state;
			if (state == noise_ctrl_pkg::idle && start_of_frame) begin
				blocks_q  <= blocks_log2;
				block_idx <= '0;
			end
			if (block_clear)
				sample_cnt <= '0;
			else if (wr_en)
				sample_cnt <= sample_cnt + 1'b1;
			if (variance_start) begin
				mean_pend <= 1'b0;
				block_idx <= block_idx + 1'b1;
				wr_bank   <= ~wr_bank; // next block goes to the other bank
			end else if (mean_ready) begin
				mean_pend <= 1'b1;
			end
		end
	end

endmodule

/* verilog/noise_estimation_top.sv */
// noise estimator top level: controller, ping-pong buffer, mean, variance, accumulator
module noise_estimation_top (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                start_of_frame,
	input  logic [2:0]                          blocks_log2,
	input  logic                                sample_valid,
	input  logic [noise_data_pkg::sample_w-1:0] sample_data,
	output logic                                sample_ready,
	output logic                                block_stat_valid,
	output noise_data_pkg::block_stat_t         block_stat,
	output logic                                noise_valid,
	output noise_data_pkg::noise_result_t       noise_result
);

	logic                                wr_en;
	logic                                wr_bank;
	logic [noise_ctrl_pkg::addr_w-1:0]   wr_addr;
	logic                                rd_bank;
	logic [noise_ctrl_pkg::addr_w-1:0]   rd_addr;
	logic [noise_data_pkg::sample_w-1:0] rd_data;
	logic                                block_clear;
	logic                                mean_ready;
	logic [noise_data_pkg::sample_w-1:0] mean;
	logic                                variance_start;
	noise_ctrl_pkg::variance_job_t       variance_job;
	logic                                variance_busy;
	logic                                variance_last;

	noise_estimation_fsm u_fsm (
		.clk            (clk),
		.rst_n          (rst_n),
		.start_of_frame (start_of_frame),
		.blocks_log2    (blocks_log2),
		.sample_valid   (sample_valid),
		.mean_ready     (mean_ready),
		.mean           (mean),
		.variance_busy  (variance_busy),
		.variance_done  (block_stat_valid),
		.variance_last  (variance_last),
		.sample_ready   (sample_ready),
		.wr_en          (wr_en),
		.wr_bank        (wr_bank),
		.wr_addr        (wr_addr),
		.block_clear    (block_clear),
		.variance_start (variance_start),
		.variance_job   (variance_job)
	);

	block_buffer u_buffer (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_bank (wr_bank),
		.wr_addr (wr_addr),
		.wr_data (sample_data),
		.rd_bank (rd_bank),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	block_mean u_mean (
		.clk           (clk),
		.rst_n         (rst_n),
		.sample_accept (wr_en), // same strobe as the buffer write
		.sample_data   (sample_data),
		.block_clear   (block_clear),
		.mean_ready    (mean_ready),
		.mean          (mean)
	);

	block_variance u_variance (
		.clk            (clk),
		.rst_n          (rst_n),
		.variance_start (variance_start),
		.variance_job   (variance_job),
		.rd_data        (rd_data),
		.rd_bank        (rd_bank),
		.rd_addr        (rd_addr),
		.variance_busy  (variance_busy),
		.variance_done  (block_stat_valid),
		.variance_last  (variance_last),
		.block_stat     (block_stat)
	);

	noise_accumulator u_accum (
		.clk           (clk),
		.rst_n         (rst_n),
		.variance_done (block_stat_valid),
		.variance_last (variance_last),
		.block_stat    (block_stat),
		.blocks_log2   (blocks_log2),
		.noise_valid   (noise_valid),
		.noise_result  (noise_result)
	);

endmodule
